//--- uart.f
src/uartPkg.sv
src/uartFifo.sv
src/uartBaud.sv
src/uartTx.sv
src/uartRx.sv
src/uartRegs.sv
src/uart.sv
testbench/uartTb.sv

//--- Makefile
# Verilator build and run of the serial port testbench

VERILATOR ?= verilator
TOP       ?= uartTb
FILELIST  ?= uart.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || echo "Checks failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/uartTb.sv
// Self-checking testbench for the serial port on a 32-bit bus with 4-deep FIFOs
// Frame formats come from a table and data bytes from an LFSR with a fixed seed
`timescale 1ns/1ps
module uartTb;

  localparam int XLEN       = 32;
  localparam int FIFO_DEPTH = 4;

  // One row per external frame case
  typedef struct packed {
    logic [7:0] lcr;
    logic [7:0] div;
    logic [7:0] count;
  } frameCaseT;

  logic            clk, rst;
  logic [1:0]      memRw;
  logic [2:0]      addr;
  logic [XLEN-1:0] wdata, rdata;
  logic            resp, ready, sin, sout, intr;
  logic [31:0]     lfsr;
  logic [7:0]      txBytes [8];
  logic            loopWatch;
  int              soutLowCycles;
  int              errors, testErrStart, testsRun, testsFailed;

  // 8N1, 8E1, 7O2, 6E1 and 5O2 at a few divisors
  frameCaseT caseTable [5] = '{
    '{8'h03, 8'd1, 8'd3},
    '{8'h1b, 8'd2, 8'd2},
    '{8'h0e, 8'd3, 8'd2},
    '{8'h19, 8'd2, 8'd3},
    '{8'h0c, 8'd1, 8'd2}
  };

  uart #(.XLEN(XLEN), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (
    .clk(clk), .rst(rst), .memRw(memRw), .addr(addr), .wdata(wdata),
    .rdata(rdata), .resp(resp), .ready(ready), .sin(sin), .sout(sout), .intr(intr)
  );

  always #4 clk = ~clk;

  // Counts cycles where sout leaves its idle level while loopback is on
  always @(negedge clk) begin
    if (loopWatch && sout !== 1'b1) soutLowCycles++;
  end

  //////////////////////////////
  // Frame rules
  //////////////////////////////

  function automatic int wordBits(input logic [7:0] lcr);
    return 5 + int'(lcr[1:0]);
  endfunction

  function automatic logic [7:0] maskFor(input logic [7:0] lcr);
    case (lcr[1:0])
      2'd0:    return 8'h1f;
      2'd1:    return 8'h3f;
      2'd2:    return 8'h7f;
      default: return 8'hff;
    endcase
  endfunction

  // Even parity makes the count of ones even and odd parity makes it odd
  function automatic logic parityFor(input logic [7:0] data, input logic [7:0] lcr);
    logic p;
    p = 1'b0;
    for (int i = 0; i < wordBits(lcr); i++) p = p ^ data[i];
    return lcr[4] ? p : !p;
  endfunction

  // Start, data, parity and stop bits last 16 ticks each
  function automatic int frameCycles(input logic [7:0] lcr, input int div);
    return (1 + wordBits(lcr) + int'(lcr[3]) + (lcr[2] ? 2 : 1)) * 16 * div;
  endfunction

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randomByte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsrNext(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic reportMismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
    $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic startTest();
    testErrStart = errors;
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errors == testErrStart) begin
      $display("Test %0d %s: ok", testsRun, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: %0d errors", testsRun, name, errors - testErrStart);
    end
  endtask

  //////////////////////////////
  // Bus model
  //////////////////////////////

  task automatic skipCycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic applyReset();
    rst = 1'b1;
    skipCycles(2);
    rst = 1'b0;
  endtask

  // The other lanes carry the inverted byte so a wrong lane select shows up
  task automatic busWrite(input logic [2:0] a, input logic [7:0] d);
    @(posedge clk);
    #1;
    memRw = 2'b01;
    addr  = a;
    wdata = ~{(XLEN/8){d}};
    wdata[{a[1:0], 3'b000} +: 8] = d;
    @(posedge clk);
    #1;
    memRw = 2'b00;
  endtask

  // Data is valid in the strobe cycle and side effects land at the next edge
  task automatic busRead(input logic [2:0] a, output logic [7:0] d);
    @(posedge clk);
    #1;
    memRw = 2'b10;
    addr  = a;
    @(negedge clk);
    d = rdata[7:0];
    if (rdata !== {(XLEN/8){rdata[7:0]}}) begin
      $display("FAILED rdata: got 0x%0h expected 0x%0h", rdata, {(XLEN/8){rdata[7:0]}});
      errors++;
    end
    if (resp !== 1'b0 || ready !== 1'b1) begin
      $display("Bus did not answer with an OK response and ready");
      errors++;
    end
    @(posedge clk);
    #1;
    memRw = 2'b00;
  endtask

  task automatic setFormat(input logic [7:0] lcr, input int div);
    busWrite(uartPkg::lcrAddr, lcr | 8'h80);
    busWrite(uartPkg::rbrThrDll, div[7:0]);
    busWrite(uartPkg::ierDlm, div[15:8]);
    busWrite(uartPkg::lcrAddr, lcr);
  endtask

  // Polls LSR and hands back the read that finds the bit
  task automatic waitLsr(input logic [2:0] bitPos, input int limit, output logic [7:0] v);
    int  waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    v      = 8'h00;
    while (!seen && waited < limit) begin
      busRead(uartPkg::lsrAddr, v);
      waited += 2;
      seen = v[bitPos];
    end
    if (!seen) begin
      $display("Timeout after %0d cycles waiting for LSR bit %0d", waited, bitPos);
      errors++;
    end
  endtask

  task automatic waitIntr(input logic level, input int limit);
    int waited;
    waited = 0;
    while (intr !== level && waited < limit) begin
      skipCycles(1);
      waited++;
    end
    if (intr !== level) begin
      $display("Timeout after %0d cycles waiting for intr to reach %0d", waited, level);
      errors++;
    end
  endtask

  //////////////////////////////
  // Serial model
  //////////////////////////////

  task automatic sendBit(input logic v, input int div);
    sin = v;
    skipCycles(16 * div);
  endtask

  task automatic driveFrame(input logic [7:0] data, input logic [7:0] lcr, input int div,
                            input logic badPar, input logic badStop);
    @(posedge clk);
    #1;
    sendBit(1'b0, div);
    for (int i = 0; i < wordBits(lcr); i++) sendBit(data[i], div);
    if (lcr[3]) sendBit(parityFor(data, lcr) ^ badPar, div);
    sendBit(!badStop, div);
    if (lcr[2]) sendBit(1'b1, div);
    sin = 1'b1;
  endtask

  // Finds the falling edge and then samples every bit at its middle
  task automatic decodeFrame(input logic [7:0] lcr, input int div, output logic [7:0] data,
                             output logic startBit, output logic parBit,
                             output logic [1:0] stopBits, output logic found);
    int waited;
    waited   = 0;
    data     = 8'h00;
    startBit = 1'b1;
    parBit   = 1'b0;
    stopBits = 2'b00;
    while (sout !== 1'b0 && waited < frameCycles(lcr, div) + 32 * div) begin
      skipCycles(1);
      waited++;
    end
    found = (sout === 1'b0);
    if (found) begin
      skipCycles(8 * div);
      startBit = sout;
      for (int i = 0; i < wordBits(lcr); i++) begin
        skipCycles(16 * div);
        data[i] = sout;
      end
      if (lcr[3]) begin
        skipCycles(16 * div);
        parBit = sout;
      end
      skipCycles(16 * div);
      stopBits[0] = sout;
      if (lcr[2]) begin
        skipCycles(16 * div);
        stopBits[1] = sout;
      end
    end
  endtask

  task automatic checkFrame(input logic [7:0] lcr, input int div, input logic [7:0] sent);
    logic [7:0] data, expData;
    logic       startBit, parBit, found;
    logic [1:0] stopBits, expStops;
    expData  = sent & maskFor(lcr);
    expStops = lcr[2] ? 2'b11 : 2'b01;
    decodeFrame(lcr, div, data, startBit, parBit, stopBits, found);
    if (!found) begin
      $display("No start bit appeared on sout before the frame timeout");
      errors++;
    end else begin
      if (startBit !== 1'b0) reportMismatch("sout start bit", 8'(startBit), 8'h00);
      if (data !== expData) reportMismatch("sout data", data, expData);
      if (lcr[3] && parBit !== parityFor(sent, lcr)) begin
        reportMismatch("sout parity", 8'(parBit), 8'(parityFor(sent, lcr)));
      end
      if (stopBits !== expStops) reportMismatch("sout stop bits", 8'(stopBits), 8'(expStops));
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [7:0] v, r, b, lcr;
    int         div, n;
    clk           = 1'b0;
    rst           = 1'b1;
    memRw         = 2'b00;
    addr          = 3'd0;
    wdata         = '0;
    sin           = 1'b1;
    lfsr          = 32'h9f64;
    loopWatch     = 1'b0;
    soutLowCycles = 0;
    errors        = 0;
    testErrStart  = 0;
    testsRun      = 0;
    testsFailed   = 0;
    applyReset();

    // Reset values, scratch register and divisor latch
    startTest();
    busRead(uartPkg::lsrAddr, v);
    if (v !== 8'h60) reportMismatch("LSR", v, 8'h60);
    busRead(uartPkg::iirAddr, v);
    if (v !== 8'h01) reportMismatch("IIR", v, 8'h01);
    if (sout !== 1'b1) reportMismatch("sout", 8'(sout), 8'h01);
    if (intr !== 1'b0) reportMismatch("intr", 8'(intr), 8'h00);
    busWrite(uartPkg::scrAddr, 8'ha5);
    busRead(uartPkg::scrAddr, v);
    if (v !== 8'ha5) reportMismatch("SCR", v, 8'ha5);
    busWrite(uartPkg::lcrAddr, 8'h80);
    busWrite(uartPkg::rbrThrDll, 8'hc3);
    busWrite(uartPkg::ierDlm, 8'h5a);
    busRead(uartPkg::rbrThrDll, v);
    if (v !== 8'hc3) reportMismatch("DLL", v, 8'hc3);
    busRead(uartPkg::ierDlm, v);
    if (v !== 8'h5a) reportMismatch("DLM", v, 8'h5a);
    busRead(uartPkg::lcrAddr, v);
    if (v !== 8'h80) reportMismatch("LCR", v, 8'h80);
    // The large divisor may already sit in the baud counter so a reset flushes it
    applyReset();
    busRead(uartPkg::lcrAddr, v);
    if (v !== 8'h00) reportMismatch("LCR", v, 8'h00);
    endTest("reset and register access");

    // Each table row is written through THR and decoded from sout
    startTest();
    for (int row = 0; row < 5; row++) begin
      lcr = caseTable[row].lcr;
      div = int'(caseTable[row].div);
      n   = int'(caseTable[row].count);
      setFormat(lcr, div);
      for (int k = 0; k < n; k++) randomByte(txBytes[k]);
      fork
        for (int k = 0; k < n; k++) busWrite(uartPkg::rbrThrDll, txBytes[k]);
        for (int k = 0; k < n; k++) checkFrame(lcr, div, txBytes[k]);
      join
      // LCR may only change once the last stop bit is out
      waitLsr(uartPkg::lsrTemt, frameCycles(lcr, div), v);
    end
    endTest("external frames");

    // Loopback with 7 data bits and even parity
    startTest();
    lcr = 8'h1a;
    div = 1;
    setFormat(lcr, div);
    busWrite(uartPkg::mcrAddr, 8'h10);
    soutLowCycles = 0;
    loopWatch     = 1'b1;
    for (int k = 0; k < 3; k++) begin
      randomByte(b);
      busWrite(uartPkg::rbrThrDll, b);
      waitLsr(uartPkg::lsrDr, 2 * frameCycles(lcr, div) + 64, v);
      if ((v & 8'h0e) !== 8'h00) reportMismatch("LSR error bits", v & 8'h0e, 8'h00);
      busRead(uartPkg::rbrThrDll, r);
      if (r !== (b & maskFor(lcr))) reportMismatch("RBR", r, b & maskFor(lcr));
    end
    waitLsr(uartPkg::lsrTemt, frameCycles(lcr, div), v);
    loopWatch = 1'b0;
    // The frames above drive start bits, so a leaking transmitter pulls sout low
    if (soutLowCycles != 0) reportMismatch("sout", 8'h00, 8'h01);
    busWrite(uartPkg::mcrAddr, 8'h00);
    endTest("loopback");

    // Wrong parity first and then a low stop bit
    startTest();
    lcr = 8'h1b;
    div = 2;
    setFormat(lcr, div);
    randomByte(b);
    driveFrame(b, lcr, div, 1'b1, 1'b0);
    waitLsr(uartPkg::lsrDr, frameCycles(lcr, div), v);
    if ((v & 8'h0e) !== 8'h04) reportMismatch("LSR error bits", v & 8'h0e, 8'h04);
    busRead(uartPkg::lsrAddr, v);
    if ((v & 8'h0e) !== 8'h00) reportMismatch("LSR error bits", v & 8'h0e, 8'h00);
    busRead(uartPkg::rbrThrDll, r);
    if (r !== b) reportMismatch("RBR", r, b);
    randomByte(b);
    driveFrame(b, lcr, div, 1'b0, 1'b1);
    waitLsr(uartPkg::lsrDr, frameCycles(lcr, div), v);
    if ((v & 8'h0e) !== 8'h08) reportMismatch("LSR error bits", v & 8'h0e, 8'h08);
    busRead(uartPkg::lsrAddr, v);
    if ((v & 8'h0e) !== 8'h00) reportMismatch("LSR error bits", v & 8'h0e, 8'h00);
    busRead(uartPkg::rbrThrDll, r);
    if (r !== b) reportMismatch("RBR", r, b);
    endTest("parity and framing errors");

    // One frame more than the receive FIFO holds
    startTest();
    lcr = 8'h03;
    div = 1;
    setFormat(lcr, div);
    for (int k = 0; k < FIFO_DEPTH + 1; k++) begin
      randomByte(txBytes[k]);
      driveFrame(txBytes[k], lcr, div, 1'b0, 1'b0);
    end
    waitLsr(uartPkg::lsrOe, frameCycles(lcr, div), v);
    if ((v & 8'h0f) !== 8'h03) reportMismatch("LSR", v & 8'h0f, 8'h03);
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      busRead(uartPkg::rbrThrDll, r);
      if (r !== txBytes[k]) reportMismatch("RBR", r, txBytes[k]);
    end
    busRead(uartPkg::lsrAddr, v);
    if ((v & 8'h0f) !== 8'h00) reportMismatch("LSR", v & 8'h0f, 8'h00);
    endTest("overrun");

    // Receive data interrupt and then the THRE interrupt
    startTest();
    busWrite(uartPkg::ierDlm, 8'h01);
    if (intr !== 1'b0) reportMismatch("intr", 8'(intr), 8'h00);
    randomByte(b);
    driveFrame(b, lcr, div, 1'b0, 1'b0);
    waitIntr(1'b1, frameCycles(lcr, div));
    busRead(uartPkg::iirAddr, v);
    if (v !== 8'h04) reportMismatch("IIR", v, 8'h04);
    busRead(uartPkg::rbrThrDll, r);
    if (r !== b) reportMismatch("RBR", r, b);
    if (intr !== 1'b0) reportMismatch("intr", 8'(intr), 8'h00);
    busWrite(uartPkg::ierDlm, 8'h02);
    randomByte(b);
    busWrite(uartPkg::rbrThrDll, b);
    // The write itself drops the pending THRE cause
    if (intr !== 1'b0) reportMismatch("intr", 8'(intr), 8'h00);
    waitIntr(1'b1, frameCycles(lcr, div));
    busRead(uartPkg::iirAddr, v);
    if (v !== 8'h02) reportMismatch("IIR", v, 8'h02);
    if (intr !== 1'b0) reportMismatch("intr", 8'(intr), 8'h00);
    waitLsr(uartPkg::lsrTemt, 2 * frameCycles(lcr, div), v);
    busWrite(uartPkg::ierDlm, 8'h00);
    endTest("interrupts");

    $display("Tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- src/uart.sv
// Memory-mapped serial port, always ready and answering in the same cycle
// XLEN must be 32 or 64 and FIFO_DEPTH a power of two
`timescale 1ns/1ps
module uart #(
  parameter int XLEN       = 32,
  parameter int FIFO_DEPTH = 16
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [1:0]      memRw,
  input  logic [2:0]      addr,
  input  logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] rdata,
  output logic            resp,
  output logic            ready,
  input  logic            sin,
  output logic            sout,
  output logic            intr
);

  logic [7:0]        din, dout;
  logic              txPush, txPop, txFull, txEmpty, txBusy;
  logic [7:0]        txData;
  logic              rxPush, rxPop, rxFull, rxEmpty, rxPe, rxFe;
  logic [7:0]        rxByte, rxData;
  uartPkg::lineCtrlT lcr;
  logic [15:0]       divisor;
  logic              loopback, baudTick, txOut, rxIn;

  // OK response with no wait states
  assign resp  = 1'b0;
  assign ready = 1'b1;

  //////////////////////////////
  // Byte lane handling
  //////////////////////////////

  // A 64-bit bus places every register in its own lane
  generate
    if (XLEN == 64) begin : gLane64
      assign din = wdata[{addr, 3'b000} +: 8];
    end else begin : gLane32
      assign din = wdata[{addr[1:0], 3'b000} +: 8];
    end
  endgenerate

  // The byte is copied to every lane so any lane the master picks is right
  assign rdata = {(XLEN/8){dout}};

  // In loopback the receiver listens to the transmitter and the pin idles
  assign rxIn = loopback ? txOut : sin;
  assign sout = loopback ? 1'b1 : txOut;

  uartRegs regs0 (
    .clk(clk), .rst(rst),
    .regAddr(addr), .regRead(memRw[1]), .regWrite(memRw[0]),
    .din(din), .dout(dout),
    .txFull(txFull), .txEmpty(txEmpty), .txBusy(txBusy), .txPush(txPush),
    .rxEmpty(rxEmpty), .rxFull(rxFull), .rxData(rxData), .rxPop(rxPop),
    .rxPush(rxPush), .rxPe(rxPe), .rxFe(rxFe),
    .lcr(lcr), .divisor(divisor), .loopback(loopback), .intr(intr)
  );

  // One tick source feeds both directions
  uartBaud baud0 (.clk(clk), .rst(rst), .divisor(divisor), .baudTick(baudTick));

  uartFifo #(.DEPTH(FIFO_DEPTH)) txFifo0 (
    .clk(clk), .rst(rst), .push(txPush), .pop(txPop), .wrData(din),
    .rdData(txData), .empty(txEmpty), .full(txFull)
  );

  uartTx tx0 (
    .clk(clk), .rst(rst), .baudTick(baudTick), .lcr(lcr),
    .txEmpty(txEmpty), .txData(txData),
    .txPop(txPop), .txBusy(txBusy), .serialOut(txOut)
  );

  uartRx rx0 (
    .clk(clk), .rst(rst), .baudTick(baudTick), .lcr(lcr), .serialIn(rxIn),
    .rxPush(rxPush), .rxByte(rxByte), .rxPe(rxPe), .rxFe(rxFe)
  );

  uartFifo #(.DEPTH(FIFO_DEPTH)) rxFifo0 (
    .clk(clk), .rst(rst), .push(rxPush), .pop(rxPop), .wrData(rxByte),
    .rdData(rxData), .empty(rxEmpty), .full(rxFull)
  );

endmodule

//--- src/uartRegs.sv
// Register file of the serial port with status, interrupt and FIFO strobes
// FCR writes are ignored since both FIFOs stay enabled
`timescale 1ns/1ps
module uartRegs (
  input  logic              clk,
  input  logic              rst,
  input  logic [2:0]        regAddr,
  input  logic              regRead,
  input  logic              regWrite,
  input  logic [7:0]        din,
  output logic [7:0]        dout,
  input  logic              txFull,
  input  logic              txEmpty,
  input  logic              txBusy,
  output logic              txPush,
  input  logic              rxEmpty,
  input  logic              rxFull,
  input  logic [7:0]        rxData,
  output logic              rxPop,
  input  logic              rxPush,
  input  logic              rxPe,
  input  logic              rxFe,
  output uartPkg::lineCtrlT lcr,
  output logic [15:0]       divisor,
  output logic              loopback,
  output logic              intr
);

  logic [2:0] ier;
  logic [7:0] scr, dll, dlm, lsr;
  logic       oe, pe, fe, threPending, txEmptyQ;
  logic       dlab, wrThr, rdIir, rdLsr, threEnable;
  logic       lineIrq, rxIrq, threIrq;
  logic [3:0] iirCode;

  assign dlab    = lcr.f.dlab;
  assign divisor = {dlm, dll};

  // Access strobes whose FIFO side effects happen at the clock edge
  assign wrThr  = regWrite && (regAddr == uartPkg::rbrThrDll) && !dlab;
  assign txPush = wrThr && !txFull;
  assign rxPop  = regRead && (regAddr == uartPkg::rbrThrDll) && !dlab && !rxEmpty;
  assign rdIir  = regRead && (regAddr == uartPkg::iirAddr);
  assign rdLsr  = regRead && (regAddr == uartPkg::lsrAddr);
  // Turning on the THRE interrupt with an empty FIFO raises it at once
  assign threEnable = regWrite && (regAddr == uartPkg::ierDlm) && !dlab &&
                      din[1] && !ier[1] && txEmpty;

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ier      <= '0;
      lcr.raw  <= '0;
      loopback <= 1'b0;
      scr      <= '0;
      dll      <= 8'd1;
      dlm      <= '0;
    end else if (regWrite) begin
      case (regAddr)
        uartPkg::rbrThrDll: if (dlab) dll <= din;
        uartPkg::ierDlm: begin
          if (dlab) dlm <= din;
          else ier <= din[2:0];
        end
        uartPkg::lcrAddr: lcr.raw  <= din;
        uartPkg::mcrAddr: loopback <= din[4];
        uartPkg::scrAddr: scr      <= din;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Status and interrupts
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      oe          <= 1'b0;
      pe          <= 1'b0;
      fe          <= 1'b0;
      threPending <= 1'b0;
      txEmptyQ    <= 1'b1;
    end else begin
      txEmptyQ <= txEmpty;
      // Reading LSR clears the errors but a new error in that cycle still lands
      if (rdLsr) begin
        oe <= 1'b0;
        pe <= 1'b0;
        fe <= 1'b0;
      end
      if (rxPush && rxFull) oe <= 1'b1;
      if (rxPush && rxPe) pe <= 1'b1;
      if (rxPush && rxFe) fe <= 1'b1;
      // THRE is an event that is armed when the transmit FIFO drains
      if (wrThr || (rdIir && iirCode == uartPkg::iirThre)) threPending <= 1'b0;
      else if ((txEmpty && !txEmptyQ) || threEnable) threPending <= 1'b1;
    end
  end

  always_comb begin
    lsr = '0;
    lsr[uartPkg::lsrDr]   = !rxEmpty;
    lsr[uartPkg::lsrOe]   = oe;
    lsr[uartPkg::lsrPe]   = pe;
    lsr[uartPkg::lsrFe]   = fe;
    lsr[uartPkg::lsrThre] = txEmpty;
    // Empty means the shifter has also sent its last stop bit
    lsr[uartPkg::lsrTemt] = txEmpty && !txBusy;
  end

  assign lineIrq = ier[2] && (oe || pe || fe);
  assign rxIrq   = ier[0] && !rxEmpty;
  assign threIrq = ier[1] && threPending;
  assign intr    = lineIrq || rxIrq || threIrq;

  // Highest priority cause wins the identification code
  always_comb begin
    if (lineIrq) iirCode = uartPkg::iirLineStat;
    else if (rxIrq) iirCode = uartPkg::iirRxData;
    else if (threIrq) iirCode = uartPkg::iirThre;
    else iirCode = uartPkg::iirNone;
  end

  // Read mux where unknown offsets such as MSR read zero
  always_comb begin
    case (regAddr)
      uartPkg::rbrThrDll: dout = dlab ? dll : (rxEmpty ? 8'h00 : rxData);
      uartPkg::ierDlm:    dout = dlab ? dlm : {5'b0, ier};
      uartPkg::iirAddr:   dout = {4'b0, iirCode};
      uartPkg::lcrAddr:   dout = lcr.raw;
      uartPkg::mcrAddr:   dout = {3'b0, loopback, 4'b0};
      uartPkg::lsrAddr:   dout = lsr;
      uartPkg::scrAddr:   dout = scr;
      default:            dout = 8'h00;
    endcase
  end

  // Every accepted THR write shows up as a non-empty FIFO one cycle later
  assert property (@(posedge clk) disable iff (rst) txPush |=> !txEmpty);

endmodule

//--- src/uartRx.sv
// Receive sampler working on the shared 16x baud tick
// Only the first stop bit is checked, break is not detected
`timescale 1ns/1ps
module uartRx (
  input  logic              clk,
  input  logic              rst,
  input  logic              baudTick,
  input  uartPkg::lineCtrlT lcr,
  input  logic              serialIn,
  output logic              rxPush,
  output logic [7:0]        rxByte,
  output logic              rxPe,
  output logic              rxFe
);

  typedef enum logic [2:0] {rxIdle, rxStart, rxData, rxParity, rxStop} rxStateT;

  rxStateT    state;
  logic       sync1, sync2;
  logic [3:0] tickCnt;
  logic [2:0] bitIdx, lastIdx;
  logic [7:0] dataReg;
  logic       peReg, midSample, startOk;

  assign lastIdx   = {1'b0, lcr.f.wordLen} + 3'd4;
  // Mid-bit point of data, parity and stop bits
  assign midSample = baudTick && (tickCnt == 4'd15);
  // Eighth tick after the falling edge, where the start bit is checked again
  assign startOk   = (state == rxStart) && baudTick && (tickCnt == 4'd7) && !sync2;

  // The push lines up with the stop-bit sample
  assign rxPush = (state == rxStop) && midSample;
  assign rxByte = dataReg;
  assign rxPe   = peReg;
  assign rxFe   = !sync2;

  //////////////////////////////
  // Input sync and bit FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sync1   <= 1'b1;
      sync2   <= 1'b1;
      state   <= rxIdle;
      tickCnt <= '0;
      bitIdx  <= '0;
      peReg   <= 1'b0;
    end else begin
      sync1 <= serialIn;
      sync2 <= sync1;
      if (baudTick) tickCnt <= tickCnt + 4'd1;
      case (state)
        rxIdle: begin
          if (baudTick && !sync2) begin
            state   <= rxStart;
            tickCnt <= '0;
          end
        end
        rxStart: begin
          if (startOk) begin
            state   <= rxData;
            tickCnt <= '0;
            bitIdx  <= '0;
            peReg   <= 1'b0;
          end else if (baudTick && tickCnt == 4'd7) begin
            // Line went high again, treat it as noise
            state <= rxIdle;
          end
        end
        rxData: begin
          if (midSample) begin
            bitIdx <= bitIdx + 3'd1;
            if (bitIdx == lastIdx) state <= lcr.f.parEn ? rxParity : rxStop;
          end
        end
        rxParity: begin
          if (midSample) begin
            peReg <= ^dataReg ^ sync2 ^ ~lcr.f.evenPar;
            state <= rxStop;
          end
        end
        rxStop: if (midSample) state <= rxIdle;
        default: state <= rxIdle;
      endcase
    end
  end

  // Cleared on a valid start so bits above the word length read as zero
  always_ff @(posedge clk) begin
    if (startOk) begin
      dataReg <= '0;
    end else if (state == rxData && midSample) begin
      dataReg[bitIdx] <= sync2;
    end
  end

endmodule

//--- src/uartTx.sv
// Transmit shifter framing one character per FIFO entry
// LCR must not change while a frame is on the line
`timescale 1ns/1ps
module uartTx (
  input  logic              clk,
  input  logic              rst,
  input  logic              baudTick,
  input  uartPkg::lineCtrlT lcr,
  input  logic              txEmpty,
  input  logic [7:0]        txData,
  output logic              txPop,
  output logic              txBusy,
  output logic              serialOut
);

  typedef enum logic [2:0] {txIdle, txStart, txBits, txParity, txStop} txStateT;

  txStateT    state;
  logic [3:0] tickCnt;
  logic [2:0] bitIdx, lastIdx;
  logic [7:0] shiftReg;
  logic       parBit, stopIdx, lineOut, bitDone;

  // Index of the final data bit runs from 4 for five bits up to 7 for eight
  assign lastIdx = {1'b0, lcr.f.wordLen} + 3'd4;
  assign bitDone = baudTick && (tickCnt == 4'd15);

  // Frames start on a tick so every bit spans exactly 16 ticks
  assign txPop  = (state == txIdle) && !txEmpty && baudTick;
  assign txBusy = (state != txIdle);

  always_comb begin
    case (state)
      txStart:  lineOut = 1'b0;
      txBits:   lineOut = shiftReg[0];
      txParity: lineOut = parBit;
      default:  lineOut = 1'b1;
    endcase
  end

  //////////////////////////////
  // Frame sequencer
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= txIdle;
      tickCnt   <= '0;
      bitIdx    <= '0;
      stopIdx   <= 1'b0;
      serialOut <= 1'b1;
    end else begin
      // Registered so the pin never glitches between states
      serialOut <= lineOut;
      if (baudTick && txBusy) tickCnt <= tickCnt + 4'd1;
      case (state)
        txIdle: begin
          if (txPop) begin
            state   <= txStart;
            tickCnt <= '0;
            bitIdx  <= '0;
            stopIdx <= 1'b0;
          end
        end
        txStart: if (bitDone) state <= txBits;
        txBits: begin
          if (bitDone) begin
            bitIdx <= bitIdx + 3'd1;
            if (bitIdx == lastIdx) state <= lcr.f.parEn ? txParity : txStop;
          end
        end
        txParity: if (bitDone) state <= txStop;
        txStop: begin
          // A second stop bit only when STB is set
          if (bitDone) begin
            stopIdx <= 1'b1;
            if (stopIdx || !lcr.f.stopSel) state <= txIdle;
          end
        end
        default: state <= txIdle;
      endcase
    end
  end

  // Character and parity are captured at the pop and the LSB goes out first
  always_ff @(posedge clk) begin
    if (txPop) begin
      shiftReg <= txData;
      parBit   <= ^(txData & uartPkg::wordMask(lcr)) ^ ~lcr.f.evenPar;
    end else if (state == txBits && bitDone) begin
      shiftReg <= shiftReg >> 1;
    end
  end

  assert property (@(posedge clk) disable iff (rst) (state == txIdle) |-> serialOut);

endmodule

//--- src/uartBaud.sv
// Baud tick generator at 16 times the bit rate
// A divisor of zero behaves as one
`timescale 1ns/1ps
module uartBaud (
  input  logic        clk,
  input  logic        rst,
  input  logic [15:0] divisor,
  output logic        baudTick
);

  logic [15:0] count, divEff;

  assign divEff = (divisor == 16'd0) ? 16'd1 : divisor;

  // The tick comes out on the zero count, so it repeats every divEff cycles
  assign baudTick = (count == 16'd0);

  // The divisor is sampled only at reload, so a change never cuts a period short
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (baudTick) begin
      count <= divEff - 16'd1;
    end else begin
      count <= count - 16'd1;
    end
  end

endmodule

//--- src/uartFifo.sv
// Byte FIFO with the head word visible on rdData
// DEPTH must be a power of two
`timescale 1ns/1ps
module uartFifo #(
  parameter int DEPTH = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  logic       pop,
  input  logic [7:0] wrData,
  output logic [7:0] rdData,
  output logic       empty,
  output logic       full
);

  localparam int AW = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  logic [AW-1:0] wrPtr, rdPtr;
  logic [AW:0] count;
  logic        doPush, doPop;

  // Overflowing pushes and underflowing pops are dropped
  assign doPush = push && !full;
  assign doPop  = pop && !empty;

  assign empty  = (count == '0);
  assign full   = (count == (AW+1)'(DEPTH));
  assign rdData = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop) rdPtr <= rdPtr + 1'b1;
      count <= count + (AW+1)'(doPush) - (AW+1)'(doPop);
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= wrData;
  end

  assert property (@(posedge clk) disable iff (rst) count <= (AW+1)'(DEPTH));

endmodule

//--- src/uartPkg.sv
// Register map and line-control layout of the 16550-style serial port
// Modem status and the FIFO control register are not modeled
package uartPkg;

  //////////////////////////////
  // Register offsets
  //////////////////////////////

  // RBR on read, THR on write, DLL while DLAB is set
  localparam logic [2:0] rbrThrDll = 3'd0;
  // IER, or DLM while DLAB is set
  localparam logic [2:0] ierDlm    = 3'd1;
  localparam logic [2:0] iirAddr   = 3'd2;
  localparam logic [2:0] lcrAddr   = 3'd3;
  localparam logic [2:0] mcrAddr   = 3'd4;
  localparam logic [2:0] lsrAddr   = 3'd5;
  localparam logic [2:0] scrAddr   = 3'd7;

  // Field view of LCR, most significant bit first
  typedef struct packed {
    logic       dlab;
    logic       brk;
    logic       stickPar;
    logic       evenPar;
    logic       parEn;
    logic       stopSel;
    logic [1:0] wordLen;
  } lineCtrlFieldsT;

  // A read returns the raw byte while the framing logic uses the fields
  typedef union packed {
    logic [7:0]     raw;
    lineCtrlFieldsT f;
  } lineCtrlT;

  // Line status bit positions
  localparam logic [2:0] lsrDr   = 3'd0;
  localparam logic [2:0] lsrOe   = 3'd1;
  localparam logic [2:0] lsrPe   = 3'd2;
  localparam logic [2:0] lsrFe   = 3'd3;
  localparam logic [2:0] lsrThre = 3'd5;
  localparam logic [2:0] lsrTemt = 3'd6;

  // Interrupt identification codes, bit 0 set means nothing pending
  localparam logic [3:0] iirNone     = 4'd1;
  localparam logic [3:0] iirThre     = 4'd2;
  localparam logic [3:0] iirRxData   = 4'd4;
  localparam logic [3:0] iirLineStat = 4'd6;

  // Mask of the active data bits, a word length code of 0 means 5 bits
  function automatic logic [7:0] wordMask(input lineCtrlT lcr);
    return 8'hff >> (2'd3 - lcr.f.wordLen);
  endfunction

endpackage
